// File: src/rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_idx_t;

  // Opcodes handled by decode
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // Immediate group funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_SRL = 7'b0000000;
  localparam logic [6:0] F7_SRA = 7'b0100000;

  localparam word_t NOP_INSN = 32'h0000_0013; // addi x0, x0, 0

  // U-type view
  typedef struct packed {
    logic [19:0] imm20;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_view_t;

  // I-type view
  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef union packed {
    u_view_t u;
    i_view_t i;
  } insn_u_t;

  typedef enum logic [1:0] {
    RET_RESET   = 2'd0,
    RET_OK      = 2'd1,
    RET_ILLEGAL = 2'd2
  } retire_e;

  typedef struct packed {
    word_t pc;
    word_t insn;
    logic  valid; // Low for reset bubbles
  } fetch_t;

  typedef struct packed {
    word_t      pc;
    word_t      insn;
    retire_e    status;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    logic       we;
    word_t      rs1_data;
    word_t      imm;     // Sign-extended imm12 or imm20 << 12
    logic [2:0] funct3;
    logic       sra;
  } exec_t;

  typedef struct packed {
    word_t    pc;
    word_t    insn;
    retire_e  status;
    reg_idx_t rd;
    logic     we;
    word_t    data;
  } result_t;

endpackage

// File: src/rv_fetch.sv
module rv_fetch #(
  parameter rv_pkg::word_t BOOT_PC = '0
) (
  input  logic           clk,
  input  logic           rst,
  input  rv_pkg::word_t  insn_i,
  output rv_pkg::word_t  pc_o,
  output rv_pkg::fetch_t fetch_o
);

  rv_pkg::word_t pc;

  assign pc_o = pc;

  // Program counter only counts up without branches
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= BOOT_PC;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // Decode register
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_o.pc    <= BOOT_PC;
      fetch_o.insn  <= rv_pkg::NOP_INSN;
      fetch_o.valid <= 1'b0; // Bubble during reset
    end else begin
      fetch_o.pc    <= pc;
      fetch_o.insn  <= insn_i; // Memory answers in the same cycle
      fetch_o.valid <= 1'b1;
    end
  end

endmodule

// File: src/rv_decode.sv
module rv_decode (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::fetch_t   fetch_i,
  output rv_pkg::reg_idx_t rs1_o,
  input  rv_pkg::word_t    rs1_data_i,
  output rv_pkg::exec_t    exec_o
);

  rv_pkg::insn_u_t  insn;
  rv_pkg::word_t    imm;
  rv_pkg::reg_idx_t rd;
  rv_pkg::retire_e  status;
  logic             is_lui;
  logic             is_op_imm;
  logic             bad_shift;
  logic             illegal;

  assign insn      = fetch_i.insn;
  assign is_lui    = (insn.u.opcode == rv_pkg::OPC_LUI);
  assign is_op_imm = (insn.i.opcode == rv_pkg::OPC_OP_IMM);

  // Right shifts carry funct7 in the upper immediate bits
  assign bad_shift = is_op_imm && (insn.i.funct3 == rv_pkg::F3_SR) &&
                     (insn.i.imm12[11:5] != rv_pkg::F7_SRL) &&
                     (insn.i.imm12[11:5] != rv_pkg::F7_SRA);
  assign illegal   = !(is_lui || is_op_imm) || bad_shift;

  always_comb begin
    if (is_lui) begin
      imm   = {insn.u.imm20, 12'b0};
      rd    = insn.u.rd;
      rs1_o = '0; // No source, so nothing gets forwarded
    end else begin
      imm   = {{(rv_pkg::XLEN-12){insn.i.imm12[11]}}, insn.i.imm12};
      rd    = insn.i.rd;
      rs1_o = is_op_imm ? insn.i.rs1 : '0;
    end
  end

  always_comb begin
    if (!fetch_i.valid) status = rv_pkg::RET_RESET;
    else if (illegal)   status = rv_pkg::RET_ILLEGAL;
    else                status = rv_pkg::RET_OK;
  end

  // Execute register
  always_ff @(posedge clk) begin
    if (rst) begin
      exec_o <= '{status: rv_pkg::RET_RESET, default: '0};
    end else begin
      exec_o <= '{
        pc:       fetch_i.pc,
        insn:     fetch_i.insn,
        status:   status,
        rd:       rd,
        rs1:      rs1_o,
        we:       (status == rv_pkg::RET_OK),
        rs1_data: rs1_data_i,
        imm:      imm,
        funct3:   insn.i.funct3,
        sra:      insn.i.imm12[10]  // funct7 bit 5
      };
    end
  end

endmodule

// File: src/rv_regfile.sv
module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  rv_pkg::word_t    rd_data_i,
  input  rv_pkg::reg_idx_t rs1_i,
  output rv_pkg::word_t    rs1_data_o
);

  localparam int NUM_REGS = 2 ** rv_pkg::REG_ADDR_W;

  rv_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin // x0 stays zero
      regs[rd_i] <= rd_data_i;
    end
  end

  // Write-through covers a writeback in the same cycle as the read
  always_comb begin
    if (rs1_i == '0) begin
      rs1_data_o = '0;
    end else if (we_i && (rd_i == rs1_i)) begin
      rs1_data_o = rd_data_i;
    end else begin
      rs1_data_o = regs[rs1_i];
    end
  end

endmodule

// File: src/rv_execute.sv
module rv_execute (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::exec_t   exec_i,
  input  rv_pkg::result_t wb_i,
  output rv_pkg::result_t mem_o
);

  rv_pkg::insn_u_t insn;
  rv_pkg::word_t   op_a;
  rv_pkg::word_t   imm;
  rv_pkg::word_t   result;
  logic [4:0]      shamt;
  logic            mem_hit;
  logic            wb_hit;
  logic            is_lui;

  assign insn   = exec_i.insn;
  assign is_lui = (insn.u.opcode == rv_pkg::OPC_LUI);
  assign imm    = exec_i.imm;
  assign shamt  = exec_i.imm[4:0];

  // Forwarding where the younger memory stage wins
  assign mem_hit = mem_o.we && (mem_o.rd != '0) && (mem_o.rd == exec_i.rs1);
  assign wb_hit  = wb_i.we && (wb_i.rd != '0) && (wb_i.rd == exec_i.rs1);

  always_comb begin
    if (mem_hit) begin
      op_a = mem_o.data;
    end else if (wb_hit) begin
      op_a = wb_i.data;
    end else begin
      op_a = exec_i.rs1_data; // Value read in decode
    end
  end

  // Immediate ALU
  always_comb begin
    result = '0;
    if (is_lui) begin
      result = imm;
    end else begin
      case (exec_i.funct3)
        rv_pkg::F3_ADD:  result = op_a + imm;
        rv_pkg::F3_SLT: begin
          result = {{(rv_pkg::XLEN-1){1'b0}}, ($signed(op_a) < $signed(imm))};
        end
        rv_pkg::F3_SLTU: begin
          result = {{(rv_pkg::XLEN-1){1'b0}}, (op_a < imm)};
        end
        rv_pkg::F3_XOR:  result = op_a ^ imm;
        rv_pkg::F3_OR:   result = op_a | imm;
        rv_pkg::F3_AND:  result = op_a & imm;
        rv_pkg::F3_SLL:  result = op_a << shamt;
        rv_pkg::F3_SR: begin
          // sra picks the arithmetic shift
          if (exec_i.sra) begin
            result = $signed(op_a) >>> shamt;
          end else begin
            result = op_a >> shamt;
          end
        end
        default: result = '0;
      endcase
    end
  end

  // Memory-stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_o <= '{status: rv_pkg::RET_RESET, default: '0};
    end else begin
      mem_o <= '{
        pc:     exec_i.pc,
        insn:   exec_i.insn,
        status: exec_i.status,
        rd:     exec_i.rd,
        we:     exec_i.we,
        data:   result
      };
    end
  end

endmodule

// File: src/rv_retire.sv
module rv_retire (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::result_t  mem_i,
  output rv_pkg::result_t  wb_o,
  output rv_pkg::word_t    trace_pc_o,
  output rv_pkg::word_t    trace_insn_o,
  output rv_pkg::retire_e  trace_status_o,
  output logic             wb_we_o,
  output rv_pkg::reg_idx_t wb_rd_o,
  output rv_pkg::word_t    wb_data_o
);

  logic bubble;

  // Writeback register fed straight from the memory stage
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_o <= '{status: rv_pkg::RET_RESET, default: '0};
    end else begin
      wb_o <= mem_i;
    end
  end

  assign bubble = (wb_o.status == rv_pkg::RET_RESET);

  // Trace shows zeros for bubbles
  assign trace_pc_o     = bubble ? '0 : wb_o.pc;
  assign trace_insn_o   = bubble ? '0 : wb_o.insn;
  assign trace_status_o = wb_o.status;

  // Register-file write request
  assign wb_we_o   = wb_o.we;
  assign wb_rd_o   = wb_o.rd;
  assign wb_data_o = wb_o.data;

endmodule

// File: src/rv_core.sv
module rv_core #(
  parameter rv_pkg::word_t BOOT_PC = '0
) (
  input  logic             clk,
  input  logic             rst,
  output rv_pkg::word_t    imem_addr_o,
  input  rv_pkg::word_t    imem_data_i,
  output rv_pkg::word_t    trace_pc_o,
  output rv_pkg::word_t    trace_insn_o,
  output rv_pkg::retire_e  trace_status_o,
  output logic             wb_we_o,
  output rv_pkg::reg_idx_t wb_rd_o,
  output rv_pkg::word_t    wb_data_o
);

  rv_pkg::fetch_t   fetch;
  rv_pkg::exec_t    exec;
  rv_pkg::result_t  mem;
  rv_pkg::result_t  wb;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::word_t    rs1_data;

  // Fetch drives the instruction memory address directly
  rv_fetch #(
    .BOOT_PC (BOOT_PC)
  ) u_fetch (
    .clk     (clk),
    .rst     (rst),
    .insn_i  (imem_data_i),
    .pc_o    (imem_addr_o),
    .fetch_o (fetch)
  );

  rv_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .fetch_i    (fetch),
    .rs1_o      (rs1),
    .rs1_data_i (rs1_data),
    .exec_o     (exec)
  );

  // Written from the writeback register
  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .we_i       (wb.we),
    .rd_i       (wb.rd),
    .rd_data_i  (wb.data),
    .rs1_i      (rs1),
    .rs1_data_o (rs1_data)
  );

  rv_execute u_execute (
    .clk    (clk),
    .rst    (rst),
    .exec_i (exec),
    .wb_i   (wb),    // Writeback bypass
    .mem_o  (mem)
  );

  rv_retire u_retire (
    .clk            (clk),
    .rst            (rst),
    .mem_i          (mem),
    .wb_o           (wb),
    .trace_pc_o     (trace_pc_o),
    .trace_insn_o   (trace_insn_o),
    .trace_status_o (trace_status_o),
    .wb_we_o        (wb_we_o),
    .wb_rd_o        (wb_rd_o),
    .wb_data_o      (wb_data_o)
  );

endmodule

// File: verif/rv_core_tb.sv
module rv_core_tb;

  localparam int PROG_WORDS = 128;

  logic             clk;
  logic             rst;
  rv_pkg::word_t    imem_addr;
  rv_pkg::word_t    imem_data;
  rv_pkg::word_t    trace_pc;
  rv_pkg::word_t    trace_insn;
  rv_pkg::retire_e  trace_status;
  logic             wb_we;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::word_t    wb_data;

  rv_pkg::word_t prog [PROG_WORDS];
  rv_pkg::word_t model_regs [32];  // Reference register file in program order
  rv_pkg::word_t exp_pc = '0;
  rv_pkg::word_t exp_fetch_pc = '0;
  logic          clk_started = 1'b0;
  int            prog_len = 0;
  int            retired = 0;
  int            post_rst_edges = 0;
  int            errors = 0;
  int            tests_passed = 0;
  int            tests_failed = 0;
  int            seed = 90;
  int            test_end [6];

  rv_core #(
    .BOOT_PC (32'h0)
  ) UUT (
    .clk            (clk),
    .rst            (rst),
    .imem_addr_o    (imem_addr),
    .imem_data_i    (imem_data),
    .trace_pc_o     (trace_pc),
    .trace_insn_o   (trace_insn),
    .trace_status_o (trace_status),
    .wb_we_o        (wb_we),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic rv_pkg::word_t prog_word(rv_pkg::word_t addr);
    if ((addr >> 2) < prog_len) return prog[addr >> 2];
    return rv_pkg::NOP_INSN; // Past the end of the program
  endfunction

  function automatic rv_pkg::word_t i_word(logic [11:0] imm, rv_pkg::reg_idx_t rs1,
                                           logic [2:0] f3, rv_pkg::reg_idx_t rd);
    return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
  endfunction

  function automatic rv_pkg::word_t u_word(logic [19:0] imm, rv_pkg::reg_idx_t rd);
    return {imm, rd, rv_pkg::OPC_LUI};
  endfunction

  function automatic rv_pkg::reg_idx_t rand_reg();
    return rv_pkg::reg_idx_t'(1 + (($random(seed) & 32'h7fff_ffff) % 31)); // x1..x31
  endfunction

  function automatic logic [11:0] rand_imm();
    return 12'($random(seed));
  endfunction

  // Legality straight from the decode rules
  function automatic logic insn_legal(rv_pkg::word_t w);
    if (w[6:0] == rv_pkg::OPC_LUI) return 1'b1;
    if (w[6:0] != rv_pkg::OPC_OP_IMM) return 1'b0;
    if (w[14:12] == rv_pkg::F3_SR) begin
      return (w[31:25] == rv_pkg::F7_SRL) || (w[31:25] == rv_pkg::F7_SRA);
    end
    return 1'b1;
  endfunction

  function automatic rv_pkg::word_t model_result(rv_pkg::word_t w, rv_pkg::word_t a);
    rv_pkg::word_t imm;
    logic [4:0]    sh;
    imm = {{20{w[31]}}, w[31:20]};
    sh  = w[24:20];
    if (w[6:0] == rv_pkg::OPC_LUI) return {w[31:12], 12'h000};
    case (w[14:12])
      rv_pkg::F3_ADD:  return a + imm;
      rv_pkg::F3_SLT:  return {31'b0, $signed(a) < $signed(imm)};
      rv_pkg::F3_SLTU: return {31'b0, a < imm};
      rv_pkg::F3_XOR:  return a ^ imm;
      rv_pkg::F3_OR:   return a | imm;
      rv_pkg::F3_AND:  return a & imm;
      rv_pkg::F3_SLL:  return a << sh;
      default: begin
        if (w[30]) return $signed(a) >>> sh; // funct7 0100000
        return a >> sh;
      end
    endcase
  endfunction

  task automatic emit(rv_pkg::word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic report_mismatch(string name, rv_pkg::word_t exp, rv_pkg::word_t act);
    $display("CHECK FAILED %s expected %h got %h (pc %h)", name, exp, act, exp_pc);
    errors++;
  endtask

  // Program segments for each test
  task automatic order_program();
    emit(rv_pkg::NOP_INSN);
    emit(i_word(12'h001, 5'd0, rv_pkg::F3_ADD, 5'd1));
    emit(i_word(12'h002, 5'd1, rv_pkg::F3_ADD, 5'd2));
    emit(i_word(12'h7ff, 5'd0, rv_pkg::F3_ADD, 5'd3));
  endtask

  task automatic lui_program();
    for (int i = 0; i < 6; i++) begin
      emit(u_word(20'($random(seed)), rand_reg()));
    end
    emit(u_word(20'hfffff, 5'd0));                    // Write to x0 is dropped
    emit(i_word(12'h000, 5'd0, rv_pkg::F3_ADD, 5'd6));
    emit(rv_pkg::NOP_INSN);
    emit(i_word(12'h000, 5'd0, rv_pkg::F3_ADD, 5'd7));
  endtask

  task automatic arith_program();
    logic [2:0] f3;
    emit(i_word(12'd5, 5'd0, rv_pkg::F3_ADD, 5'd1));
    emit(i_word(12'hffb, 5'd0, rv_pkg::F3_ADD, 5'd2)); // -5
    emit(i_word(12'hffb, 5'd1, rv_pkg::F3_SLT, 5'd3));
    emit(i_word(12'd5, 5'd2, rv_pkg::F3_SLT, 5'd4));
    emit(i_word(12'hffb, 5'd1, rv_pkg::F3_SLTU, 5'd5));
    emit(i_word(12'd5, 5'd2, rv_pkg::F3_SLTU, 5'd6));
    for (int i = 0; i < 12; i++) begin
      case (i % 3)
        0:       f3 = rv_pkg::F3_ADD;
        1:       f3 = rv_pkg::F3_SLT;
        default: f3 = rv_pkg::F3_SLTU;
      endcase
      emit(i_word(rand_imm(), rand_reg(), f3, rand_reg()));
    end
  endtask

  task automatic logic_program();
    logic [4:0] shamts [3];
    shamts[0] = 5'd0;
    shamts[1] = 5'd31;
    shamts[2] = 5'($random(seed));
    emit(u_word({1'b1, 19'($random(seed))}, 5'd8)); // Top bit set
    emit(i_word(rand_imm(), 5'd8, rv_pkg::F3_XOR, 5'd9));
    emit(i_word(rand_imm(), 5'd8, rv_pkg::F3_OR, 5'd10));
    emit(i_word(rand_imm(), 5'd8, rv_pkg::F3_AND, 5'd11));
    for (int i = 0; i < 3; i++) begin
      emit(i_word({7'b0000000, shamts[i]}, 5'd8, rv_pkg::F3_SLL, 5'd12));
      emit(i_word({rv_pkg::F7_SRL, shamts[i]}, 5'd8, rv_pkg::F3_SR, 5'd13));
      emit(i_word({rv_pkg::F7_SRA, shamts[i]}, 5'd8, rv_pkg::F3_SR, 5'd14));
    end
  endtask

  task automatic bypass_program();
    rv_pkg::reg_idx_t prev;
    rv_pkg::reg_idx_t next;
    emit(i_word(12'h123, 5'd0, rv_pkg::F3_ADD, 5'd15));
    emit(i_word(12'h001, 5'd15, rv_pkg::F3_ADD, 5'd16)); // Distance 1
    emit(i_word(12'h002, 5'd15, rv_pkg::F3_ADD, 5'd17)); // Distance 2
    emit(i_word(12'h003, 5'd15, rv_pkg::F3_ADD, 5'd18)); // Distance 3
    emit(i_word(12'h111, 5'd0, rv_pkg::F3_ADD, 5'd19));
    emit(i_word(12'h222, 5'd0, rv_pkg::F3_ADD, 5'd19));
    emit(i_word(12'h000, 5'd19, rv_pkg::F3_ADD, 5'd20)); // Younger x19 wins
    emit(i_word(12'h555, 5'd0, rv_pkg::F3_ADD, 5'd0));
    emit(i_word(12'h007, 5'd0, rv_pkg::F3_ADD, 5'd21));
    emit(u_word(20'habcde, 5'd0));
    emit(rv_pkg::NOP_INSN);
    emit(i_word(12'h009, 5'd0, rv_pkg::F3_ADD, 5'd22));
    prev = 5'd15;
    for (int i = 0; i < 6; i++) begin
      next = rand_reg();
      emit(i_word(rand_imm(), prev, (i % 2) ? rv_pkg::F3_XOR : rv_pkg::F3_ADD, next));
      prev = next;
    end
  endtask

  task automatic illegal_program();
    emit(i_word(12'h0aa, 5'd0, rv_pkg::F3_ADD, 5'd24));
    emit({12'h001, 5'd24, 3'b000, 5'd24, 7'b0110011}); // Register-register add
    emit(i_word(12'h001, 5'd24, rv_pkg::F3_ADD, 5'd25));
    emit({25'h1ff_ffff, 7'b1111111});
    emit(i_word({7'b0010000, 5'd3}, 5'd24, rv_pkg::F3_SR, 5'd24)); // Bad funct7
    emit(i_word(12'h000, 5'd24, rv_pkg::F3_ADD, 5'd26));
    emit(rv_pkg::NOP_INSN);
    emit(rv_pkg::NOP_INSN);
    emit(i_word(12'h000, 5'd24, rv_pkg::F3_ADD, 5'd27));
  endtask

  task automatic check_retirement();
    rv_pkg::word_t   w;
    rv_pkg::word_t   res;
    rv_pkg::retire_e exp_status;
    logic            legal;
    w     = prog_word(exp_pc);
    legal = insn_legal(w);
    res   = model_result(w, model_regs[w[19:15]]);
    exp_status = legal ? rv_pkg::RET_OK : rv_pkg::RET_ILLEGAL;
    assert (trace_pc == exp_pc) else report_mismatch("trace_pc_o", exp_pc, trace_pc);
    assert (trace_insn == w) else report_mismatch("trace_insn_o", w, trace_insn);
    assert (trace_status == exp_status)
      else report_mismatch("trace_status_o", 32'(exp_status), 32'(trace_status));
    assert (wb_we == legal) else report_mismatch("wb_we_o", 32'(legal), 32'(wb_we));
    if (legal) begin
      assert (wb_rd == w[11:7]) else report_mismatch("wb_rd_o", 32'(w[11:7]), 32'(wb_rd));
      assert (wb_data == res) else report_mismatch("wb_data_o", res, wb_data);
      if (w[11:7] != 5'd0) model_regs[w[11:7]] = res;
    end
    exp_pc += 4;
    retired++;
  endtask

  always @(posedge clk) begin
    clk_started <= 1'b1;
    if (rst) begin
      post_rst_edges <= 0;
      exp_fetch_pc   <= '0;
    end else begin
      exp_fetch_pc <= exp_fetch_pc + 32'd4; // Fetch advances every cycle
      if (post_rst_edges < 8) begin
        post_rst_edges <= post_rst_edges + 1;
      end
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (clk_started) begin
      assert (imem_addr == exp_fetch_pc)
        else report_mismatch("imem_addr_o", exp_fetch_pc, imem_addr);
      if (rst || post_rst_edges < 4) begin
        assert (trace_status == rv_pkg::RET_RESET)
          else report_mismatch("trace_status_o", 32'(rv_pkg::RET_RESET), 32'(trace_status));
        assert (trace_insn == '0) else report_mismatch("trace_insn_o", 32'h0, trace_insn);
        assert (!wb_we) else report_mismatch("wb_we_o", 32'h0, 32'(wb_we));
      end else begin
        check_retirement();
      end
    end
  end

  // Instruction memory answers a short delay after the edge
  always @(posedge clk) begin
    #10;
    imem_data = prog_word(imem_addr);
  end

  task automatic run_test(input string name, input int last);
    int cycles;
    int errors_before;
    cycles = 0;
    errors_before = errors;
    while (retired < last && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    if (retired < last) begin
      $display("Timeout in test %s, %0d of %0d instructions retired", name, retired, last);
      errors++;
    end
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    rst = 1'b1;
    imem_data = rv_pkg::NOP_INSN;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    order_program();
    test_end[0] = prog_len;
    lui_program();
    test_end[1] = prog_len;
    arith_program();
    test_end[2] = prog_len;
    logic_program();
    test_end[3] = prog_len;
    bypass_program();
    test_end[4] = prog_len;
    illegal_program();
    test_end[5] = prog_len;
    repeat (8) @(posedge clk);
    #10 rst = 1'b0;
    run_test("reset and order", test_end[0]);
    run_test("lui", test_end[1]);
    run_test("arithmetic and compares", test_end[2]);
    run_test("logic and shifts", test_end[3]);
    run_test("bypass", test_end[4]);
    run_test("illegal instructions", test_end[5]);
    $display("Tests passed: %0d, failed: %0d, check errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: flist.f
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_retire.sv
src/rv_core.sv
verif/rv_core_tb.sv
